// ==== spu_mul_unit.f ====
hdl/spu_bus_pkg.sv
hdl/spu_mul_cfg_pkg.sv
hdl/spu_mul_cfg_regs.sv
hdl/spu_op_mulsu.sv
hdl/spu_mul_unit.sv
bench/spu_mul_unit_assertions.sv
bench/tb_spu_mul_unit.sv

// ==== Bender.yml ====
package:
  name: spu_mul_unit

sources:
  # design
  - files:
      - hdl/spu_bus_pkg.sv
      - hdl/spu_mul_cfg_pkg.sv
      - hdl/spu_mul_cfg_regs.sv
      - hdl/spu_op_mulsu.sv
      - hdl/spu_mul_unit.sv

  # testbench
  - target: test
    files:
      - bench/spu_mul_unit_assertions.sv
      - bench/tb_spu_mul_unit.sv

// ==== bench/tb_spu_mul_unit.sv ====
`timescale 1ns/1ps

module tb_spu_mul_unit;

    localparam int DATA0_BITS    = spu_bus_pkg::DATA0_BITS_DEFAULT;
    localparam int DATA1_BITS    = spu_bus_pkg::DATA1_BITS_DEFAULT;
    localparam int M_DATA_BITS   = spu_bus_pkg::M_DATA_BITS_DEFAULT;
    localparam int LATENCY       = spu_bus_pkg::LATENCY_DEFAULT;
    localparam int DRAIN_TIMEOUT = 20 * LATENCY + 50;

    // one item with the configuration it entered with
    typedef struct packed {
        logic                           valid;
        logic                           clear;
        logic [DATA0_BITS-1:0]          d0;
        logic [DATA1_BITS-1:0]          op1;
        spu_mul_cfg_pkg::shift_amt_t    shift;
        logic [M_DATA_BITS-1:0]         clear_value;
    } item_t;

    logic                       clk;
    logic                       reset;
    logic                       cfg_write;
    spu_bus_pkg::cfg_addr_t     cfg_addr;
    spu_bus_pkg::cfg_word_t     cfg_wdata;
    logic                       cke;
    logic [DATA0_BITS-1:0]      data0;
    logic [DATA1_BITS-1:0]      data1;
    logic                       in_clear;
    logic                       in_valid;
    logic [M_DATA_BITS-1:0]     out_data;
    logic                       out_update;

    integer seed = 32'h8113;
    int errors = 0;
    int checks = 0;

    // ------------------------------
    // model state
    // ------------------------------

    item_t                          pipe [0:LATENCY-1];
    item_t                          new_item;
    logic [M_DATA_BITS-1:0]         exp_data;
    logic                           exp_update;
    logic                           model_ready = 1'b0;     // set by first reset edge
    spu_mul_cfg_pkg::shift_amt_t    m_shift;
    logic [M_DATA_BITS-1:0]         m_clear_value;
    logic [DATA1_BITS-1:0]          m_imm;
    logic                           m_use_imm;

    spu_mul_unit dut0 (
        .clk        (clk),
        .reset      (reset),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cke        (cke),
        .data0      (data0),
        .data1      (data1),
        .in_clear   (in_clear),
        .in_valid   (in_valid),
        .out_data   (out_data),
        .out_update (out_update)
    );

    bind spu_mul_unit spu_mul_unit_assertions #(
        .M_DATA_BITS (M_DATA_BITS)
    ) asrt0 (
        .clk        (clk),
        .reset      (reset),
        .out_data   (out_data),
        .out_update (out_update)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // helpers
    // ------------------------------

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // zero, ones, min, max, one-hot, inverted one-hot, random
    function automatic logic [31:0] pattern_value(input int sel, input int width);
        logic [31:0] mask;
        logic [31:0] hot;
        mask = (width >= 32) ? '1 : ((32'd1 << width) - 1);
        hot  = 32'd1 << rand_below(width);
        case (sel)
            0:       return 32'd0;
            1:       return mask;
            2:       return 32'd1 << (width - 1);
            3:       return (32'd1 << (width - 1)) - 1;
            4:       return hot;
            5:       return ~hot & mask;
            default: return $random(seed) & mask;
        endcase
    endfunction

    // expected output register after this item reaches the end
    function automatic logic [M_DATA_BITS-1:0] ref_out(input item_t it,
                                                       input logic [M_DATA_BITS-1:0] prev);
        longint a;
        longint b;
        longint p;
        if (it.clear) begin
            return it.clear_value;
        end
        if (!it.valid) begin
            return prev;
        end
        a = longint'($signed(it.d0));       // signed operand
        b = longint'(it.op1);               // unsigned operand
        p = (a * b) >>> it.shift;
        return M_DATA_BITS'(p);
    endfunction

    function automatic bit pipe_busy();
        for (int i = 0; i < LATENCY; i++) begin
            if (pipe[i].valid || pipe[i].clear) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // ------------------------------
    // model and compare
    // ------------------------------

    always @(posedge clk) begin
        if (model_ready) begin
            checks = checks + 2;
            assert (out_data === exp_data) else begin
                errors++;
                $display("** Error at %t: out_data expected %h, actual %h",
                         $time, exp_data, out_data);
            end
            assert (out_update === exp_update) else begin
                errors++;
                $display("** Error at %t: out_update expected %b, actual %b",
                         $time, exp_update, out_update);
            end
        end
        if (reset) begin
            for (int i = 0; i < LATENCY; i++) begin
                pipe[i] = '0;
            end
            m_shift       = '0;
            m_clear_value = '0;
            m_imm         = '0;
            m_use_imm     = 1'b0;
            exp_data      = '0;
            exp_update    = 1'b0;
            model_ready   = 1'b1;
        end else begin
            exp_update = 1'b0;
            if (cke) begin
                new_item.valid       = in_valid;
                new_item.clear       = in_clear;
                new_item.d0          = data0;
                new_item.op1         = m_use_imm ? m_imm : data1;
                new_item.shift       = m_shift;         // config as of this edge
                new_item.clear_value = m_clear_value;
                for (int i = LATENCY - 1; i > 0; i--) begin
                    pipe[i] = pipe[i-1];
                end
                pipe[0]    = new_item;
                exp_data   = ref_out(pipe[LATENCY-1], exp_data);
                exp_update = pipe[LATENCY-1].valid | pipe[LATENCY-1].clear;
            end
            if (cfg_write) begin
                case (cfg_addr)
                    spu_mul_cfg_pkg::ADDR_SHIFT: m_shift = cfg_wdata[5:0];
                    spu_mul_cfg_pkg::ADDR_CLEAR: m_clear_value = cfg_wdata[M_DATA_BITS-1:0];
                    spu_mul_cfg_pkg::ADDR_IMM:   m_imm = cfg_wdata[DATA1_BITS-1:0];
                    default: m_use_imm = cfg_wdata[spu_mul_cfg_pkg::CTRL_USE_IMM];
                endcase
            end
        end
    end

    // ------------------------------
    // stimulus tasks
    // ------------------------------

    task automatic run_items(input int n_items, input int valid_pct, input int clear_pct,
                             input bit walk);
        int done_items;
        int cycles;
        int sel0;
        int sel1;
        done_items = 0;
        cycles     = 0;
        while (done_items < n_items && cycles < 4 * n_items + 20) begin
            @(negedge clk);
            cycles++;
            if (walk) begin
                sel0 = done_items % 7;          // every pattern pair in turn
                sel1 = (done_items / 7) % 7;
            end else begin
                sel0 = rand_below(7);
                sel1 = rand_below(7);
            end
            data0    = DATA0_BITS'(pattern_value(sel0, DATA0_BITS));
            data1    = DATA1_BITS'(pattern_value(sel1, DATA1_BITS));
            in_valid = rand_below(100) < valid_pct;
            in_clear = rand_below(100) < clear_pct;
            cke      = rand_below(10) != 0;     // low about one cycle in ten
            if (cke) begin
                done_items++;
            end
        end
        if (done_items < n_items) begin
            errors++;
            $display("timeout: only %0d of %0d items entered the pipeline", done_items, n_items);
        end
    endtask

    task automatic drain_pipe();
        int cycles;
        cycles = 0;
        @(negedge clk);
        in_valid = 1'b0;
        in_clear = 1'b0;
        while (pipe_busy() && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cke = rand_below(10) != 0;
            cycles++;
        end
        if (pipe_busy()) begin
            errors++;
            $display("timeout: pipeline still holds items after %0d cycles", cycles);
        end
    endtask

    task automatic write_cfg(input spu_bus_pkg::cfg_addr_t addr,
                             input spu_bus_pkg::cfg_word_t value);
        @(negedge clk);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = value;
        @(negedge clk);
        cfg_write = 1'b0;
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------

    initial begin
        $timeformat(-9, 1, " ns", 10);
        reset     = 1'b1;
        cfg_write = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        cke       = 1'b0;
        data0     = '0;
        data1     = '0;
        in_clear  = 1'b0;
        in_valid  = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        run_items(256, 80, 0, 1'b1);        // default config, pattern walk
        run_items(200, 50, 0, 1'b0);        // many holds

        drain_pipe();
        write_cfg(spu_mul_cfg_pkg::ADDR_CLEAR, 32'h0000_a55a);
        run_items(200, 70, 25, 1'b0);

        for (int s = 0; s <= M_DATA_BITS + 2; s++) begin
            drain_pipe();
            write_cfg(spu_mul_cfg_pkg::ADDR_SHIFT, spu_bus_pkg::cfg_word_t'(s));
            run_items(40, 85, 5, 1'b0);
        end
        drain_pipe();
        write_cfg(spu_mul_cfg_pkg::ADDR_SHIFT, 32'd0);

        // immediate operand on, then off again
        drain_pipe();
        write_cfg(spu_mul_cfg_pkg::ADDR_IMM, 32'h0000_00b3);
        write_cfg(spu_mul_cfg_pkg::ADDR_CTRL, 32'd1 << spu_mul_cfg_pkg::CTRL_USE_IMM);
        run_items(100, 85, 0, 1'b0);
        drain_pipe();
        write_cfg(spu_mul_cfg_pkg::ADDR_CTRL, 32'd0);
        run_items(100, 85, 0, 1'b0);

        // reset with items in flight
        write_cfg(spu_mul_cfg_pkg::ADDR_SHIFT, 32'd3);
        write_cfg(spu_mul_cfg_pkg::ADDR_CTRL, 32'd1 << spu_mul_cfg_pkg::CTRL_USE_IMM);
        run_items(30, 70, 20, 1'b0);
        pulse_reset();
        run_items(60, 80, 0, 1'b0);

        drain_pipe();
        @(negedge clk);                     // last update flag compared
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/spu_mul_unit_assertions.sv ====
`timescale 1ns/1ps

module spu_mul_unit_assertions #(
    parameter int M_DATA_BITS = 8
) (
    input logic                     clk,
    input logic                     reset,
    input logic [M_DATA_BITS-1:0]   out_data,
    input logic                     out_update
);

    // ------------------------------
    // reset behavior
    // ------------------------------

    // reset held over an edge clears the update flag
    property p_update_low_in_reset;
        @(posedge clk) reset && $past(reset) |-> !out_update;
    endproperty

    a_update_low_in_reset: assert property (p_update_low_in_reset)
        else $error("out_update high while reset is held");

    // pipeline flags cleared by reset so the first free edge loads nothing
    property p_no_update_after_release;
        @(posedge clk) $fell(reset) |=> !out_update;
    endproperty

    a_no_update_after_release: assert property (p_no_update_after_release)
        else $error("out_update high right after reset release");

    // ------------------------------
    // output hold
    // ------------------------------

    // out_data only moves on a load, which raises out_update
    property p_data_stable_without_update;
        @(posedge clk) !reset && !$past(reset) && !out_update |-> $stable(out_data);
    endproperty

    a_data_stable_without_update: assert property (p_data_stable_without_update)
        else $error("out_data changed without out_update");

endmodule

// ==== hdl/spu_mul_unit.sv ====
`timescale 1ns/1ps

module spu_mul_unit #(
    parameter int DATA0_BITS  = spu_bus_pkg::DATA0_BITS_DEFAULT,
    parameter int DATA1_BITS  = spu_bus_pkg::DATA1_BITS_DEFAULT,
    parameter int M_DATA_BITS = spu_bus_pkg::M_DATA_BITS_DEFAULT,
    parameter int LATENCY     = spu_bus_pkg::LATENCY_DEFAULT
) (
    input  logic                        clk,
    input  logic                        reset,

    // configuration writes
    input  logic                        cfg_write,
    input  spu_bus_pkg::cfg_addr_t      cfg_addr,
    input  spu_bus_pkg::cfg_word_t      cfg_wdata,

    // item stream
    input  logic                        cke,
    input  logic [DATA0_BITS-1:0]       data0,
    input  logic [DATA1_BITS-1:0]       data1,
    input  logic                        in_clear,
    input  logic                        in_valid,

    output logic [M_DATA_BITS-1:0]      out_data,
    output logic                        out_update
);

    // ------------------------------
    // register block to datapath
    // ------------------------------

    spu_mul_cfg_pkg::shift_amt_t    shift_amt;
    logic [M_DATA_BITS-1:0]         clear_value;
    logic [DATA1_BITS-1:0]          imm_data;
    logic                           use_imm;

    spu_mul_cfg_regs #(
        .M_DATA_BITS (M_DATA_BITS),
        .DATA1_BITS  (DATA1_BITS)
    ) cfg0 (
        .clk         (clk),
        .reset       (reset),
        .cfg_write   (cfg_write),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .shift_amt   (shift_amt),
        .clear_value (clear_value),
        .imm_data    (imm_data),
        .use_imm     (use_imm)
    );

    spu_op_mulsu #(
        .DATA0_BITS  (DATA0_BITS),
        .DATA1_BITS  (DATA1_BITS),
        .M_DATA_BITS (M_DATA_BITS),
        .LATENCY     (LATENCY)
    ) mul0 (
        .clk         (clk),
        .reset       (reset),
        .cke         (cke),
        .data0       (data0),
        .data1       (data1),
        .in_clear    (in_clear),
        .in_valid    (in_valid),
        .shift_amt   (shift_amt),
        .clear_value (clear_value),
        .imm_data    (imm_data),
        .use_imm     (use_imm),
        .out_data    (out_data),
        .out_update  (out_update)
    );

endmodule

// ==== hdl/spu_op_mulsu.sv ====
`timescale 1ns/1ps

module spu_op_mulsu #(
    parameter int DATA0_BITS  = 8,
    parameter int DATA1_BITS  = 8,
    parameter int M_DATA_BITS = 8,
    parameter int LATENCY     = 3
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cke,

    input  logic [DATA0_BITS-1:0]       data0,
    input  logic [DATA1_BITS-1:0]       data1,
    input  logic                        in_clear,
    input  logic                        in_valid,

    input  spu_mul_cfg_pkg::shift_amt_t shift_amt,
    input  logic [M_DATA_BITS-1:0]      clear_value,
    input  logic [DATA1_BITS-1:0]       imm_data,
    input  logic                        use_imm,

    output logic [M_DATA_BITS-1:0]      out_data,
    output logic                        out_update
);

    // one spare bit so the zero-extended operand stays positive
    localparam int PROD_BITS  = DATA0_BITS + DATA1_BITS + 1;
    localparam int EXT_BITS   = (PROD_BITS > M_DATA_BITS) ? PROD_BITS : M_DATA_BITS;
    localparam int MID_STAGES = (LATENCY > 2) ? LATENCY - 2 : 0;

    // ------------------------------
    // input stage
    // ------------------------------

    logic [DATA1_BITS-1:0]          op1;
    logic [PROD_BITS-1:0]           a_ext;
    logic [PROD_BITS-1:0]           b_ext;

    assign op1   = use_imm ? imm_data : data1;
    assign a_ext = PROD_BITS'($signed(data0));      // sign extend
    assign b_ext = PROD_BITS'(op1);                 // zero extend

    logic [PROD_BITS-1:0]           s1_a;
    logic [PROD_BITS-1:0]           s1_b;
    logic                           s1_valid;
    logic                           s1_clear;
    spu_mul_cfg_pkg::shift_amt_t    s1_shift;
    logic [M_DATA_BITS-1:0]         s1_clear_value;

    generate
        if (LATENCY >= 2) begin : g_in_reg
            always_ff @(posedge clk) begin
                if (reset) begin
                    s1_valid <= 1'b0;
                    s1_clear <= 1'b0;
                end else if (cke) begin
                    s1_valid <= in_valid;
                    s1_clear <= in_clear;
                end
            end

            // config captured with the item
            always_ff @(posedge clk) begin
                if (cke) begin
                    s1_a           <= a_ext;
                    s1_b           <= b_ext;
                    s1_shift       <= shift_amt;
                    s1_clear_value <= clear_value;
                end
            end
        end else begin : g_in_comb
            // single stage, output register samples the inputs directly
            assign s1_a           = a_ext;
            assign s1_b           = b_ext;
            assign s1_valid       = in_valid;
            assign s1_clear       = in_clear;
            assign s1_shift       = shift_amt;
            assign s1_clear_value = clear_value;
        end
    endgenerate

    // ------------------------------
    // product and delay chain
    // ------------------------------

    logic [PROD_BITS-1:0]           mid_prod        [0:MID_STAGES];
    logic                           mid_valid       [0:MID_STAGES];
    logic                           mid_clear       [0:MID_STAGES];
    spu_mul_cfg_pkg::shift_amt_t    mid_shift       [0:MID_STAGES];
    logic [M_DATA_BITS-1:0]         mid_clear_value [0:MID_STAGES];

    // exact, the true product fits in PROD_BITS
    assign mid_prod[0]        = PROD_BITS'($signed(s1_a) * $signed(s1_b));
    assign mid_valid[0]       = s1_valid;
    assign mid_clear[0]       = s1_clear;
    assign mid_shift[0]       = s1_shift;
    assign mid_clear_value[0] = s1_clear_value;

    generate
        for (genvar i = 1; i <= MID_STAGES; i++) begin : g_mid
            always_ff @(posedge clk) begin
                if (reset) begin
                    mid_valid[i] <= 1'b0;
                    mid_clear[i] <= 1'b0;
                end else if (cke) begin
                    mid_valid[i] <= mid_valid[i-1];
                    mid_clear[i] <= mid_clear[i-1];
                end
            end

            always_ff @(posedge clk) begin
                if (cke) begin
                    mid_prod[i]        <= mid_prod[i-1];
                    mid_shift[i]       <= mid_shift[i-1];
                    mid_clear_value[i] <= mid_clear_value[i-1];
                end
            end
        end
    endgenerate

    // ------------------------------
    // output stage
    // ------------------------------

    logic [EXT_BITS-1:0]            res_ext;
    logic [EXT_BITS-1:0]            res_shift;
    logic                           load;

    // widen first so narrow products still sign fill the result
    assign res_ext   = EXT_BITS'($signed(mid_prod[MID_STAGES]));
    assign res_shift = $signed(res_ext) >>> mid_shift[MID_STAGES];
    assign load      = mid_clear[MID_STAGES] | mid_valid[MID_STAGES];

    always_ff @(posedge clk) begin
        if (reset) begin
            out_data   <= '0;
            out_update <= 1'b0;
        end else begin
            out_update <= cke & load;       // follows the load edge, not cke
            if (cke) begin
                if (mid_clear[MID_STAGES]) begin
                    out_data <= mid_clear_value[MID_STAGES];   // clear wins
                end else if (mid_valid[MID_STAGES]) begin
                    out_data <= res_shift[M_DATA_BITS-1:0];
                end
            end
        end
    end

endmodule

// ==== hdl/spu_mul_cfg_regs.sv ====
`timescale 1ns/1ps

module spu_mul_cfg_regs #(
    parameter int M_DATA_BITS = 8,
    parameter int DATA1_BITS  = 8
) (
    input  logic                        clk,
    input  logic                        reset,

    // write port, no handshake
    input  logic                        cfg_write,
    input  spu_bus_pkg::cfg_addr_t      cfg_addr,
    input  spu_bus_pkg::cfg_word_t      cfg_wdata,

    // to the datapath
    output spu_mul_cfg_pkg::shift_amt_t shift_amt,
    output logic [M_DATA_BITS-1:0]      clear_value,
    output logic [DATA1_BITS-1:0]       imm_data,
    output logic                        use_imm
);

    // ------------------------------
    // write decode
    // ------------------------------

    logic wr_shift;
    logic wr_clear;
    logic wr_imm;
    logic wr_ctrl;

    always_comb begin
        wr_shift = 1'b0;
        wr_clear = 1'b0;
        wr_imm   = 1'b0;
        wr_ctrl  = 1'b0;
        if (cfg_write) begin
            case (cfg_addr)
                spu_mul_cfg_pkg::ADDR_SHIFT: wr_shift = 1'b1;
                spu_mul_cfg_pkg::ADDR_CLEAR: wr_clear = 1'b1;
                spu_mul_cfg_pkg::ADDR_IMM:   wr_imm   = 1'b1;
                spu_mul_cfg_pkg::ADDR_CTRL:  wr_ctrl  = 1'b1;
                default: ;
            endcase
        end
    end

    // ------------------------------
    // registers
    // ------------------------------

    // cke does not gate writes
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_amt   <= '0;
            clear_value <= '0;
            imm_data    <= '0;
            use_imm     <= 1'b0;
        end else begin
            if (wr_shift) begin
                // large amounts kept, datapath then gives sign bits
                shift_amt <= spu_mul_cfg_pkg::shift_amt_t'(cfg_wdata);
            end
            if (wr_clear) begin
                clear_value <= M_DATA_BITS'(cfg_wdata);     // low bits only
            end
            if (wr_imm) begin
                imm_data <= DATA1_BITS'(cfg_wdata);         // low bits only
            end
            if (wr_ctrl) begin
                use_imm <= cfg_wdata[spu_mul_cfg_pkg::CTRL_USE_IMM];
            end
        end
    end

endmodule

// ==== hdl/spu_mul_cfg_pkg.sv ====
package spu_mul_cfg_pkg;

    // ------------------------------
    // field types
    // ------------------------------

    // arithmetic right shift applied to the product
    typedef logic [5:0] shift_amt_t;

    // ------------------------------
    // register map
    // ------------------------------

    localparam spu_bus_pkg::cfg_addr_t ADDR_SHIFT = 2'd0;     // shift amount

    localparam spu_bus_pkg::cfg_addr_t ADDR_CLEAR = 2'd1;     // clear value, low M_DATA_BITS

    localparam spu_bus_pkg::cfg_addr_t ADDR_IMM = 2'd2;       // immediate operand 1

    localparam spu_bus_pkg::cfg_addr_t ADDR_CTRL = 2'd3;      // control bits

    // ------------------------------
    // control register bits
    // ------------------------------

    // operand 1 from the immediate register instead of data1
    localparam int CTRL_USE_IMM = 0;

endpackage

// ==== hdl/spu_bus_pkg.sv ====
package spu_bus_pkg;

    // ------------------------------
    // configuration write bus
    // ------------------------------

    // register address, four registers
    typedef logic [1:0] cfg_addr_t;

    // write data word
    typedef logic [31:0] cfg_word_t;

    // ------------------------------
    // default datapath shape
    // ------------------------------

    localparam int DATA0_BITS_DEFAULT = 8;      // operand 0, read as signed

    localparam int DATA1_BITS_DEFAULT = 8;      // operand 1, read as unsigned

    localparam int M_DATA_BITS_DEFAULT = 8;     // result after shift and truncation

    // enabled edges from sampling to output register load,
    // the sampling edge counted as the first
    localparam int LATENCY_DEFAULT = 3;

endpackage
